//--- design/z8_settings.svh
`ifndef Z8_SETTINGS_SVH
`define Z8_SETTINGS_SVH

// Program address and data widths
`define Z8_ADDR_WIDTH 16
`define Z8_DATA_WIDTH 8

// General registers at 00 up to 7F
`define Z8_REG_COUNT 128

// First instruction follows the interrupt vectors
`define Z8_RESET_PC 16'h000C

// Control registers in the upper register page
`define Z8_FLAGS_ADDR 8'hFC
`define Z8_RP_ADDR 8'hFD

`endif

//--- design/z8IsaPkg.sv
package z8IsaPkg;

    // High nibble of the two-operand ALU opcodes
    typedef enum logic [3:0] {
        aluAdd = 4'h0,
        aluAdc = 4'h1,
        aluSub = 4'h2,
        aluSbc = 4'h3,
        aluOr  = 4'h4,
        aluAnd = 4'h5,
        aluTcm = 4'h6,
        aluTm  = 4'h7,
        aluCp  = 4'hA,
        aluXor = 4'hB
    } aluOp;

    // Bit 3 inverts the test of the lower three bits
    typedef enum logic [3:0] {
        ccF   = 4'h0,
        ccLt  = 4'h1,
        ccLe  = 4'h2,
        ccUle = 4'h3,
        ccOv  = 4'h4,
        ccMi  = 4'h5,
        ccZ   = 4'h6,
        ccC   = 4'h7,
        ccT   = 4'h8,
        ccGe  = 4'h9,
        ccGt  = 4'hA,
        ccUgt = 4'hB,
        ccNov = 4'hC,
        ccPl  = 4'hD,
        ccNz  = 4'hE,
        ccNc  = 4'hF
    } condCode;

    typedef enum logic [2:0] {
        flagV = 3'd4,
        flagS = 3'd5,
        flagZ = 3'd6,
        flagC = 3'd7
    } flagIndex;

    typedef struct packed {
        logic [3:0] dst;
        logic [3:0] src;
    } regPair;

    // Second instruction byte
    typedef union packed {
        regPair     pair;
        logic [7:0] raw;
    } operandByte;

endpackage

//--- design/z8CorePkg.sv
`include "z8_settings.svh"

package z8CorePkg;

    // One decode cycle, then either the ALU cycle or a plain writeback
    typedef enum logic [1:0] {
        idle,
        decode,
        aluExec,
        writeback
    } execState;

    typedef logic [`Z8_DATA_WIDTH-1:0] regAddr;

endpackage

//--- design/z8Interfaces.sv
`include "z8_settings.svh"

interface fetchBus;
    import z8IsaPkg::*;

    logic                      instrValid;
    logic [`Z8_DATA_WIDTH-1:0] opcode;
    operandByte                second;
    logic [`Z8_DATA_WIDTH-1:0] third;
    logic                      instrTaken;
    logic                      loadPc;
    logic [`Z8_ADDR_WIDTH-1:0] jumpTarget;

    modport fetcher (
        output instrValid, opcode, second, third,
        input  instrTaken, loadPc, jumpTarget
    );

    modport executor (
        input  instrValid, opcode, second, third,
        output instrTaken, loadPc, jumpTarget
    );
endinterface

interface regPort;
    import z8CorePkg::*;

    regAddr                    addrA;
    regAddr                    addrB;
    logic                      workA;
    logic                      workB;
    logic [`Z8_DATA_WIDTH-1:0] dataA;
    logic [`Z8_DATA_WIDTH-1:0] dataB;
    logic                      writeEn;
    regAddr                    writeAddr;
    logic [`Z8_DATA_WIDTH-1:0] writeData;
    logic                      flagsWrite;
    logic [`Z8_DATA_WIDTH-1:0] flagsIn;
    logic [`Z8_DATA_WIDTH-1:0] flags;
    logic                      rpWrite;

    modport control (
        output addrA, addrB, workA, workB, writeEn, writeAddr, writeData,
        output flagsWrite, flagsIn, rpWrite,
        input  dataA, dataB, flags
    );

    modport file (
        input  addrA, addrB, workA, workB, writeEn, writeAddr, writeData,
        input  flagsWrite, flagsIn, rpWrite,
        output dataA, dataB, flags
    );
endinterface

//--- design/alu.sv
`include "z8_settings.svh"

module alu (
    input  z8IsaPkg::aluOp            op,
    input  logic [`Z8_DATA_WIDTH-1:0] a,
    input  logic [`Z8_DATA_WIDTH-1:0] b,
    input  logic                      carryIn,
    output logic [`Z8_DATA_WIDTH-1:0] result,
    output logic [`Z8_DATA_WIDTH-1:0] flagsOut,
    output logic                      writesResult
);
    import z8IsaPkg::*;

    localparam int Msb = `Z8_DATA_WIDTH - 1;

    logic [`Z8_DATA_WIDTH:0] wide;
    logic arith;
    logic isSub;
    logic overflow;

    // Top bit of wide is carry or borrow, logic ops pass the old carry
    always_comb begin
        arith = 1'b1;
        isSub = 1'b0;
        case (op)
            aluAdd: wide = {1'b0, a} + {1'b0, b};
            aluAdc: wide = {1'b0, a} + {1'b0, b} + carryIn;
            aluSub, aluCp: begin
                wide = {1'b0, a} - {1'b0, b};
                isSub = 1'b1;
            end
            aluSbc: begin
                wide = {1'b0, a} - {1'b0, b} - carryIn;
                isSub = 1'b1;
            end
            aluOr: begin
                wide = {carryIn, a | b};
                arith = 1'b0;
            end
            aluAnd, aluTm: begin
                wide = {carryIn, a & b};
                arith = 1'b0;
            end
            aluTcm: begin
                wide = {carryIn, ~a & b};
                arith = 1'b0;
            end
            aluXor: begin
                wide = {carryIn, a ^ b};
                arith = 1'b0;
            end
            default: begin
                wide = {carryIn, a};
                arith = 1'b0;
            end
        endcase
    end

    assign result = wide[Msb:0];

    // Signed overflow, operand signs then result sign
    assign overflow = isSub ? (a[Msb] != b[Msb]) && (result[Msb] != a[Msb])
                            : (a[Msb] == b[Msb]) && (result[Msb] != a[Msb]);

    always_comb begin
        flagsOut = '0;
        flagsOut[flagC] = wide[`Z8_DATA_WIDTH];
        flagsOut[flagZ] = result == '0;
        flagsOut[flagS] = result[Msb];
        flagsOut[flagV] = arith && overflow;
    end

    assign writesResult = !(op inside {aluTcm, aluTm, aluCp});
endmodule

//--- design/registerFile.sv
`include "z8_settings.svh"

module registerFile (
    input logic  clk,
    input logic  reset,
    regPort.file regs
);
    import z8CorePkg::*;

    localparam int IdxWidth = $clog2(`Z8_REG_COUNT);

    logic [`Z8_DATA_WIDTH-1:0] gpr [`Z8_REG_COUNT];
    logic [3:0] rp;
    logic [`Z8_DATA_WIDTH-1:0] flagReg;
    regAddr effA;
    regAddr effB;

    function automatic logic [`Z8_DATA_WIDTH-1:0] readByte(input regAddr addr);
        if (addr < `Z8_REG_COUNT) begin
            return gpr[addr[IdxWidth-1:0]];
        end else if (addr == `Z8_FLAGS_ADDR) begin
            return flagReg;
        end else if (addr == `Z8_RP_ADDR) begin
            return {rp, 4'h0};
        end
        return '0;
    endfunction

    // Working register r is rp:r
    assign effA = regs.workA ? {rp, regs.addrA[3:0]} : regs.addrA;
    assign effB = regs.workB ? {rp, regs.addrB[3:0]} : regs.addrB;

    always_comb begin
        regs.dataA = readByte(effA);
        regs.dataB = readByte(effB);
    end

    assign regs.flags = flagReg;

    always_ff @(posedge clk) begin
        if (regs.writeEn && regs.writeAddr < `Z8_REG_COUNT) begin
            gpr[regs.writeAddr[IdxWidth-1:0]] <= regs.writeData;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rp <= 4'h0;
            flagReg <= '0;
        end else begin
            // ALU flags override a result written to FC
            if (regs.flagsWrite) begin
                flagReg <= regs.flagsIn;
            end else if (regs.writeEn && regs.writeAddr == `Z8_FLAGS_ADDR) begin
                flagReg <= regs.writeData;
            end
            if (regs.rpWrite || (regs.writeEn && regs.writeAddr == `Z8_RP_ADDR)) begin
                rp <= regs.writeData[7:4];
            end
        end
    end
endmodule

//--- design/fetchUnit.sv
`include "z8_settings.svh"

module fetchUnit (
    input  logic                      clk,
    input  logic                      reset,
    output logic [`Z8_ADDR_WIDTH-1:0] pAddr,
    output logic                      pSel,
    output logic                      pEnable,
    input  logic                      pReady,
    input  logic [`Z8_DATA_WIDTH-1:0] pRdata,
    fetchBus.fetcher                  fetch
);
    logic [`Z8_ADDR_WIDTH-1:0] pc;
    logic [1:0] byteIdx;
    logic [1:0] instrLen;
    logic transferDone;
    logic lastByte;

    // Length from the low nibble, xC is the two-byte ld r,#imm
    function automatic logic [1:0] instrLength(input logic [`Z8_DATA_WIDTH-1:0] op);
        case (op[3:0])
            4'hF: return 2'd1;
            4'h6, 4'hD: return 2'd3;
            default: return 2'd2;
        endcase
    endfunction

    assign pAddr = pc;
    assign transferDone = pSel && pEnable && pReady;
    // Opcode is still on pRdata while the first byte completes
    assign instrLen = (byteIdx == 2'd0) ? instrLength(pRdata) : instrLength(fetch.opcode);
    assign lastByte = (byteIdx + 2'd1) == instrLen;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `Z8_RESET_PC;
            pSel <= 1'b0;
            pEnable <= 1'b0;
            byteIdx <= 2'd0;
            fetch.instrValid <= 1'b0;
        end else if (fetch.instrValid) begin
            if (fetch.instrTaken) begin
                fetch.instrValid <= 1'b0;
                pSel <= 1'b1;
                if (fetch.loadPc) begin
                    pc <= fetch.jumpTarget;
                end
            end
        end else if (!pSel) begin
            pSel <= 1'b1;
        end else if (!pEnable) begin
            pEnable <= 1'b1;
        end else if (pReady) begin
            pEnable <= 1'b0;
            pc <= pc + 1'b1;
            if (lastByte) begin
                pSel <= 1'b0;
                byteIdx <= 2'd0;
                fetch.instrValid <= 1'b1;
            end else begin
                byteIdx <= byteIdx + 2'd1;
            end
        end
    end

    // Instruction bytes
    always_ff @(posedge clk) begin
        if (transferDone) begin
            case (byteIdx)
                2'd0: fetch.opcode <= pRdata;
                2'd1: fetch.second.raw <= pRdata;
                default: fetch.third <= pRdata;
            endcase
        end
    end
endmodule

//--- design/executeControl.sv
`include "z8_settings.svh"

module executeControl (
    input  logic                      clk,
    input  logic                      reset,
    fetchBus.executor                 fetch,
    regPort.control                   regs,
    input  logic [`Z8_ADDR_WIDTH-1:0] pc,
    output logic                      wrValid,
    output z8CorePkg::regAddr         wrAddr,
    output logic [`Z8_DATA_WIDTH-1:0] wrData
);
    import z8IsaPkg::*;
    import z8CorePkg::*;

    execState state;
    logic [`Z8_DATA_WIDTH-1:0] opcode;
    operandByte second;
    logic [`Z8_DATA_WIDTH-1:0] third;
    logic [3:0] rpHigh;
    logic [`Z8_DATA_WIDTH-1:0] aluA;
    logic [`Z8_DATA_WIDTH-1:0] aluB;
    regAddr destAddr;

    logic [3:0] highNib;
    logic [3:0] lowNib;
    logic isAluReg, isAluImm, isLdWork, isLdReg, isSrp, isCarryOp;
    logic destIsWork;
    logic [3:0] destNum;

    aluOp op;
    logic [`Z8_DATA_WIDTH-1:0] aluResult;
    logic [`Z8_DATA_WIDTH-1:0] aluFlags;
    logic aluWrites;
    logic [`Z8_DATA_WIDTH-1:0] carryFlags;

    condCode cc;
    logic condBase;
    logic takeBranch;
    logic isJump;

    function automatic logic isAluCode(input logic [3:0] code);
        return code inside {[4'h0:4'h7], 4'hA, 4'hB};
    endfunction

    assign highNib = opcode[7:4];
    assign lowNib = opcode[3:0];
    assign isAluReg = isAluCode(highNib) && lowNib == 4'h2;
    assign isAluImm = isAluCode(highNib) && lowNib == 4'h6;
    assign isLdWork = lowNib == 4'hC;
    assign isLdReg = opcode == 8'hE6;
    assign isSrp = opcode == 8'h31;
    assign isCarryOp = opcode inside {8'hCF, 8'hDF, 8'hEF};
    assign op = aluOp'(highNib);

    // Condition test on the offered opcode, jump resolves as it is taken
    always_comb begin
        cc = condCode'(fetch.opcode[7:4]);
        case (condCode'({1'b0, cc[2:0]}))
            ccLt: condBase = regs.flags[flagS] ^ regs.flags[flagV];
            ccLe: condBase = (regs.flags[flagS] ^ regs.flags[flagV]) | regs.flags[flagZ];
            ccUle: condBase = regs.flags[flagC] | regs.flags[flagZ];
            ccOv: condBase = regs.flags[flagV];
            ccMi: condBase = regs.flags[flagS];
            ccZ: condBase = regs.flags[flagZ];
            ccC: condBase = regs.flags[flagC];
            default: condBase = 1'b0;
        endcase
        takeBranch = condBase ^ cc[3];
    end

    assign isJump = fetch.opcode[3:0] == 4'hB || fetch.opcode[3:0] == 4'hD;
    assign fetch.instrTaken = state == idle && fetch.instrValid;
    assign fetch.loadPc = fetch.instrTaken && isJump && takeBranch;
    // jr offsets from the PC after the instruction
    assign fetch.jumpTarget = (fetch.opcode[3:0] == 4'hD)
        ? {fetch.second.raw, fetch.third}
        : pc + {{(`Z8_ADDR_WIDTH - `Z8_DATA_WIDTH){fetch.second.raw[7]}}, fetch.second.raw};

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= idle;
        end else begin
            case (state)
                idle: if (fetch.instrTaken) state <= decode;
                decode: state <= (isAluReg || isAluImm) ? aluExec : writeback;
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fetch.instrTaken) begin
            opcode <= fetch.opcode;
            second <= fetch.second;
            third <= fetch.third;
            rpHigh <= regs.dataB[7:4];
        end
        if (state == decode) begin
            aluA <= regs.dataA;
            aluB <= isAluReg ? regs.dataB : third;
            destAddr <= destIsWork ? {rpHigh, destNum} : second.raw;
        end
    end

    // E-page direct addresses fold into working registers
    assign destIsWork = isAluReg || isLdWork || second.raw[7:4] == 4'hE;
    assign destNum = isAluReg ? second.pair.dst : (isLdWork ? highNib : second.raw[3:0]);

    // Port A reads the destination, port B the source or the pointer while idle
    assign regs.addrA = destIsWork ? {4'h0, destNum} : second.raw;
    assign regs.workA = destIsWork;
    assign regs.addrB = (state == idle) ? `Z8_RP_ADDR : {4'h0, second.pair.src};
    assign regs.workB = state != idle;

    always_comb begin
        carryFlags = regs.flags;
        carryFlags[flagC] = (highNib == 4'hE) ? ~regs.flags[flagC] : highNib[0];
    end

    always_comb begin
        regs.writeEn = 1'b0;
        regs.rpWrite = 1'b0;
        regs.flagsWrite = 1'b0;
        regs.flagsIn = aluFlags;
        regs.writeData = aluResult;
        if (state == aluExec) begin
            regs.writeEn = aluWrites;
            regs.flagsWrite = 1'b1;
        end else if (state == writeback) begin
            regs.writeEn = isLdWork || isLdReg;
            regs.rpWrite = isSrp;
            regs.flagsWrite = isCarryOp;
            regs.flagsIn = carryFlags;
            regs.writeData = isLdReg ? third : second.raw;
        end
    end

    assign regs.writeAddr = isSrp ? `Z8_RP_ADDR : destAddr;

    assign wrValid = regs.writeEn || regs.rpWrite;
    assign wrAddr = regs.writeAddr;
    assign wrData = regs.writeData;

    alu aluUnit (
        .op(op),
        .a(aluA),
        .b(aluB),
        .carryIn(regs.flags[flagC]),
        .result(aluResult),
        .flagsOut(aluFlags),
        .writesResult(aluWrites)
    );
endmodule

//--- design/z8Core.sv
`include "z8_settings.svh"

module z8Core (
    input  logic                      clk,
    input  logic                      reset,
    output logic [`Z8_ADDR_WIDTH-1:0] pAddr,
    output logic                      pSel,
    output logic                      pEnable,
    input  logic                      pReady,
    input  logic [`Z8_DATA_WIDTH-1:0] pRdata,
    output logic                      wrValid,
    output z8CorePkg::regAddr         wrAddr,
    output logic [`Z8_DATA_WIDTH-1:0] wrData,
    output logic [`Z8_DATA_WIDTH-1:0] flags
);
    fetchBus fetch ();
    regPort regs ();

    fetchUnit fetcher (
        .clk(clk),
        .reset(reset),
        .pAddr(pAddr),
        .pSel(pSel),
        .pEnable(pEnable),
        .pReady(pReady),
        .pRdata(pRdata),
        .fetch(fetch.fetcher)
    );

    // pAddr holds the sequential PC while an instruction is offered
    executeControl control (
        .clk(clk),
        .reset(reset),
        .fetch(fetch.executor),
        .regs(regs.control),
        .pc(pAddr),
        .wrValid(wrValid),
        .wrAddr(wrAddr),
        .wrData(wrData)
    );

    registerFile regFile (
        .clk(clk),
        .reset(reset),
        .regs(regs.file)
    );

    assign flags = regs.flags;
endmodule

//--- testbench/z8Core_properties.sv
`include "z8_settings.svh"

module z8CoreProperties (
    input logic                      clk,
    input logic                      reset,
    input logic [`Z8_ADDR_WIDTH-1:0] pAddr,
    input logic                      pSel,
    input logic                      pEnable,
    input logic                      pReady,
    input logic                      wrValid
);
    timeunit 1ns;
    timeprecision 1ps;

    // Reset as sampled on the previous edge
    logic resetSeen;
    // Failed assertions so far
    int violations = 0;

    always_ff @(posedge clk) begin
        resetSeen <= reset;
    end

    setupBeforeAccess: assert property (
        @(posedge clk) disable iff (reset)
        $rose(pEnable) |-> $past(pSel && !pEnable)
    ) else begin
        $error("pEnable rose without a preceding setup cycle");
        violations++;
    end

    addrHeld: assert property (
        @(posedge clk) disable iff (reset)
        (pSel && !pReady) |=> $stable(pAddr)
    ) else begin
        $error("pAddr changed during an unfinished transfer");
        violations++;
    end

    quietInReset: assert property (
        @(posedge clk)
        (reset && resetSeen) |-> (!wrValid && !pSel)
    ) else begin
        $error("wrValid or pSel high during reset");
        violations++;
    end
endmodule

//--- testbench/z8CoreTb.sv
`include "z8_settings.svh"

module z8CoreTb;
    timeunit 1ns;
    timeprecision 1ps;

    // Expected register write or first fetch after a jump
    typedef struct packed {
        logic        isJump;
        logic [15:0] where;
        logic [15:0] value;
        logic [7:0]  flags;
    } expectEvent;

    localparam int Timeout = 200;

    logic clk;
    logic reset;
    logic [`Z8_ADDR_WIDTH-1:0] pAddr;
    logic pSel;
    logic pEnable;
    logic pReady;
    logic [`Z8_DATA_WIDTH-1:0] pRdata;
    logic wrValid;
    logic [7:0] wrAddr;
    logic [`Z8_DATA_WIDTH-1:0] wrData;
    logic [`Z8_DATA_WIDTH-1:0] flags;

    logic [7:0] mem [2**`Z8_ADDR_WIDTH];
    logic [15:0] progAddr;
    logic [15:0] lastDone = 16'hFFFF;
    int waitLeft;
    expectEvent eventTable[$];

    z8Core uut (
        .clk(clk),
        .reset(reset),
        .pAddr(pAddr),
        .pSel(pSel),
        .pEnable(pEnable),
        .pReady(pReady),
        .pRdata(pRdata),
        .wrValid(wrValid),
        .wrAddr(wrAddr),
        .wrData(wrData),
        .flags(flags)
    );

    bind z8Core z8CoreProperties apbChecks (
        .clk(clk),
        .reset(reset),
        .pAddr(pAddr),
        .pSel(pSel),
        .pEnable(pEnable),
        .pReady(pReady),
        .wrValid(wrValid)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Memory model with 0 to 3 wait states per transfer
    initial begin
        void'($urandom(32'h5646_7af9));
        forever begin
            @(negedge clk);
            if (reset || !pSel) begin
                pReady <= 1'b0;
            end else if (!pEnable) begin
                waitLeft = $urandom % 4;
                pReady <= 1'b0;
            end else if (waitLeft == 0) begin
                pReady <= 1'b1;
                pRdata <= mem[pAddr];
            end else begin
                waitLeft = waitLeft - 1;
                pReady <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        if (pSel && pEnable && pReady) begin
            lastDone <= pAddr;
        end
    end

    task automatic failRun(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "Simulation stopped after an error");
    endtask

    always @(negedge clk) begin
        if (uut.apbChecks.violations != 0) begin
            failRun("A bound APB assertion failed");
        end
    end

    task automatic checkValue(input string name, input logic [15:0] got,
                              input logic [15:0] expected);
        if (got !== expected) begin
            failRun($sformatf("MISMATCH at %0t: %s is %h, expected %h",
                              $time, name, got, expected));
        end
    endtask

    task automatic op1(input logic [7:0] b0);
        mem[progAddr] = b0;
        progAddr = progAddr + 1;
    endtask

    task automatic op2(input logic [7:0] b0, input logic [7:0] b1);
        op1(b0);
        op1(b1);
    endtask

    task automatic op3(input logic [7:0] b0, input logic [7:0] b1, input logic [7:0] b2);
        op2(b0, b1);
        op1(b2);
    endtask

    task automatic expectWrite(input logic [7:0] addr, input logic [7:0] data,
                               input logic [7:0] fl);
        eventTable.push_back('{1'b0, {8'h00, addr}, {8'h00, data}, fl});
    endtask

    task automatic expectJump(input logic [15:0] lastByte, input logic [15:0] target,
                              input logic [7:0] fl);
        eventTable.push_back('{1'b1, lastByte, target, fl});
    endtask

    task automatic awaitWrite(input expectEvent ev, input int idx);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > Timeout) begin
                failRun($sformatf("Timeout: event %0d, the write to register %h never came",
                                  idx, ev.where[7:0]));
            end
        end while (!wrValid);
        checkValue("wrAddr", wrAddr, ev.where);
        checkValue("wrData", wrData, ev.value);
        @(negedge clk);
        checkValue("flags", flags, ev.flags);
    endtask

    task automatic awaitJump(input expectEvent ev, input int idx);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (wrValid) begin
                failRun($sformatf("Unexpected register write before jump event %0d", idx));
            end
            if (cycles > Timeout) begin
                failRun($sformatf("Timeout: event %0d, the jump at %h was never fetched",
                                  idx, ev.where));
            end
        end while (lastDone != ev.where);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > Timeout) begin
                failRun($sformatf("Timeout: event %0d, no fetch followed the jump", idx));
            end
        end while (!(pSel && !pEnable));
        checkValue("pAddr", pAddr, ev.value);
        @(negedge clk);
        checkValue("flags", flags, ev.flags);
    endtask

    initial begin
        int cycles;
        reset = 1'b1;
        pReady = 1'b0;
        pRdata = '0;

        for (int i = 0; i < 2**`Z8_ADDR_WIDTH; i++) begin
            mem[i] = i[7:0] ^ i[15:8] ^ 8'h5A;
        end
        progAddr = `Z8_RESET_PC;
        // Loads and the register pointer
        op2(8'h31, 8'h10);
        expectWrite(8'hFD, 8'h10, 8'h00);
        op2(8'h0C, 8'h05);
        expectWrite(8'h10, 8'h05, 8'h00);
        op2(8'h1C, 8'h7F);
        expectWrite(8'h11, 8'h7F, 8'h00);
        op3(8'hE6, 8'hE2, 8'h80);
        expectWrite(8'h12, 8'h80, 8'h00);
        op3(8'hE6, 8'h20, 8'h33);
        expectWrite(8'h20, 8'h33, 8'h00);
        // Arithmetic
        op2(8'h02, 8'h01);
        expectWrite(8'h10, 8'h84, 8'h30);
        op3(8'h06, 8'h20, 8'h90);
        expectWrite(8'h20, 8'hC3, 8'h20);
        op2(8'h02, 8'h12);
        expectWrite(8'h11, 8'hFF, 8'h20);
        op3(8'h16, 8'hE0, 8'h7C);
        expectWrite(8'h10, 8'h00, 8'hC0);
        op2(8'h12, 8'h21);
        expectWrite(8'h12, 8'h80, 8'hA0);
        op2(8'h22, 8'h21);
        expectWrite(8'h12, 8'h81, 8'hA0);
        op3(8'h26, 8'h11, 8'h01);
        expectWrite(8'h11, 8'hFE, 8'h20);
        op3(8'h36, 8'h10, 8'h01);
        expectWrite(8'h10, 8'hFF, 8'hA0);
        op2(8'h32, 8'h21);
        expectWrite(8'h12, 8'h82, 8'hA0);
        op3(8'h26, 8'h20, 8'h7F);
        expectWrite(8'h20, 8'h44, 8'h10);
        // Logic keeps C and clears V
        op1(8'hDF);
        op3(8'h46, 8'h11, 8'h01);
        expectWrite(8'h11, 8'hFF, 8'hA0);
        op2(8'h52, 8'h01);
        expectWrite(8'h10, 8'hFF, 8'hA0);
        op2(8'hB2, 8'h00);
        expectWrite(8'h10, 8'h00, 8'hC0);
        // Compare and test ops followed by branches
        op3(8'hA6, 8'h20, 8'h44);
        op2(8'h6B, 8'h03);
        expectJump(16'h003D, 16'h0041, 8'h40);
        op2(8'h0C, 8'h99);
        op1(8'hFF);
        op3(8'h76, 8'h20, 8'h04);
        op2(8'hEB, 8'h05);
        expectJump(16'h0045, 16'h004B, 8'h00);
        op2(8'h1C, 8'h99);
        op2(8'h2C, 8'h99);
        op1(8'hFF);
        op2(8'h6B, 8'h7F);
        expectJump(16'h004C, 16'h004D, 8'h00);
        op1(8'hDF);
        op3(8'h66, 8'h20, 8'hBB);
        op3(8'h7D, 8'h00, 8'h58);
        expectJump(16'h0053, 16'h0058, 8'hA0);
        op2(8'h0C, 8'h99);
        op2(8'h1C, 8'h99);
        op1(8'hEF);
        op3(8'hFD, 8'h00, 8'h60);
        expectJump(16'h005B, 16'h0060, 8'h20);
        op2(8'h0C, 8'h99);
        op2(8'h1C, 8'h99);
        op1(8'hDF);
        op1(8'hCF);
        op3(8'h7D, 8'h00, 8'h70);
        expectJump(16'h0064, 16'h0065, 8'h20);
        op2(8'hA2, 8'h01);
        op2(8'h3B, 8'h02);
        expectJump(16'h0068, 16'h006B, 8'h80);
        op2(8'h0C, 8'h99);
        op3(8'h0D, 8'h00, 8'h80);
        expectJump(16'h006D, 16'h006E, 8'h80);
        op2(8'h1B, 8'h02);
        expectJump(16'h006F, 16'h0070, 8'h80);
        op2(8'hBB, 8'h02);
        expectJump(16'h0071, 16'h0072, 8'h80);
        op2(8'hDC, 8'h55);
        expectWrite(8'h1D, 8'h55, 8'h80);
        op1(8'hFF);
        // Park on a self loop
        op2(8'h8B, 8'hFE);
        expectJump(16'h0076, 16'h0075, 8'h80);

        repeat (10) @(negedge clk);
        reset = 1'b0;

        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (wrValid) begin
                failRun("A register write occurred before the first fetch");
            end
            if (cycles > Timeout) begin
                failRun("Timeout: the first fetch after reset never started");
            end
        end while (!(pSel && !pEnable));
        checkValue("pAddr", pAddr, `Z8_RESET_PC);

        foreach (eventTable[i]) begin
            if (eventTable[i].isJump) begin
                awaitJump(eventTable[i], i);
            end else begin
                awaitWrite(eventTable[i], i);
            end
        end

        repeat (30) begin
            @(negedge clk);
            if (wrValid) begin
                failRun("A register write occurred after the last expected event");
            end
        end
        if (uut.apbChecks.violations == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            failRun("A bound APB assertion failed");
        end
    end
endmodule

//--- sources.f
+incdir+design
design/z8IsaPkg.sv
design/z8CorePkg.sv
design/z8Interfaces.sv
design/alu.sv
design/registerFile.sv
design/fetchUnit.sv
design/executeControl.sv
design/z8Core.sv
testbench/z8Core_properties.sv
testbench/z8CoreTb.sv

//--- Bender.yml
package:
  name: z8Core

sources:
  - include_dirs:
      - design
    files:
      - design/z8IsaPkg.sv
      - design/z8CorePkg.sv
      - design/z8Interfaces.sv
      - design/alu.sv
      - design/registerFile.sv
      - design/fetchUnit.sv
      - design/executeControl.sv
      - design/z8Core.sv
  - target: test
    include_dirs:
      - design
    files:
      - testbench/z8Core_properties.sv
      - testbench/z8CoreTb.sv
